// File: core_tests.txt
// columns: inst fetch_fault rd wen value except (hex)
// except: 0 none, 1 inst_fault, 2 inst_illegal; pc is the row index times 4
123450B7 0 01 1 12345000 0 // lui x1, 0x12345
67808093 0 01 1 12345678 0 // addi x1, x1, 0x678
FFD00113 0 02 1 FFFFFFFD 0 // addi x2, x0, -3
002081B3 0 03 1 12345675 0 // add x3, x1, x2
40208233 0 04 1 1234567B 0 // sub x4, x1, x2
0041F2B3 0 05 1 12345671 0 // and x5, x3, x4
0041E333 0 06 1 1234567F 0 // or x6, x3, x4
0041C3B3 0 07 1 0000000E 0 // xor x7, x3, x4
00112433 0 08 1 00000001 0 // slt x8, x2, x1
0020A4B3 0 09 1 00000000 0 // slt x9, x1, x2
00709533 0 0A 1 159E0000 0 // sll x10, x1, x7
007155B3 0 0B 1 0003FFFF 0 // srl x11, x2, x7
40715633 0 0C 1 FFFFFFFF 0 // sra x12, x2, x7
FFF0C693 0 0D 1 EDCBA987 0 // xori x13, x1, -1
FFE12713 0 0E 1 00000001 0 // slti x14, x2, -2
4046D793 0 0F 1 FEDCBA98 0 // srai x15, x13, 4
0F06F813 0 10 1 00000080 0 // andi x16, x13, 0xf0
00108013 0 00 0 12345679 0 // addi x0, x1, 1
001008B3 0 11 1 12345678 0 // add x17, x0, x1
0020B1B3 0 03 0 00000000 2 // sltu x3, x1, x2 is not supported
00018913 0 12 1 12345675 0 // addi x18, x3, 0
00700993 1 13 0 00000000 1 // addi x19, x0, 7 with fetch fault
FFFFFFFF 1 1F 0 00000000 1 // unknown opcode with fetch fault
0000000B 0 00 0 00000000 2 // unknown opcode
00098A33 0 14 1 00000000 0 // add x20, x19, x0
FFFFFAB7 0 15 1 FFFFF000 0 // lui x21, 0xfffff
FFFA8A93 0 15 1 FFFFEFFF 0 // addi x21, x21, -1

// File: core.f
core_pkg.sv
exe_res_if.sv
inst_decoder.sv
decode.sv
execute.sv
result.sv
core_top.sv
tb_clock.sv
tb_core.sv

// File: Makefile
VERILATOR  ?= verilator
LINT_FLAGS ?= --lint-only --timing
SIM_FLAGS  ?= --binary --timing -j 0
TOP        ?= tb_core
FILELIST   ?= core.f
OBJ_DIR    ?= obj_dir
PASS_MSG   := Regression passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: tb_core.sv
`timescale 1ns/1ps

module tb_core;

    localparam int MEM_AW = 9;
    localparam int MEM_WORDS = 1 << MEM_AW;
    localparam int COLS = 6;
    localparam int MAX_TESTS = MEM_WORDS / COLS;
    localparam int DRAIN_CYCLES = 10;

    logic clk;
    logic rst;
    logic i_inst_vld;
    logic [31:0] i_inst;
    logic [31:0] i_pc;
    logic i_fetch_fault;
    logic o_can_deq;
    logic i_ret_rdy;
    logic o_ret_vld;
    logic [31:0] o_ret_pc;
    logic o_ret_wen;
    logic [4:0] o_ret_rd_idx;
    logic [31:0] o_ret_value;
    logic [1:0] o_ret_except;

    // one row per test holding inst, fetch fault, rd, wen, value and except
    logic [31:0] test_mem [MEM_WORDS];

    int n_tests;
    int issue_idx;
    int ret_idx;
    int pass_count;
    int fail_count;
    int misc_errors;
    int cycle_count = 0;
    int cycle_limit = 0;
    logic [31:0] rand_word;
    logic [31:0] row_word;

    tb_clock tb_clock_i (
        .o_clk (clk)
    );

    core_top core_top_i (
        .clk           (clk),
        .rst           (rst),
        .i_inst_vld    (i_inst_vld),
        .i_inst        (i_inst),
        .i_pc          (i_pc),
        .i_fetch_fault (i_fetch_fault),
        .o_can_deq     (o_can_deq),
        .i_ret_rdy     (i_ret_rdy),
        .o_ret_vld     (o_ret_vld),
        .o_ret_pc      (o_ret_pc),
        .o_ret_wen     (o_ret_wen),
        .o_ret_rd_idx  (o_ret_rd_idx),
        .o_ret_value   (o_ret_value),
        .o_ret_except  (o_ret_except)
    );

    function automatic logic [31:0] test_field(input int test, input int col);
        return test_mem[MEM_AW'(test * COLS + col)];
    endfunction

    // compare the record on the retire ports with row idx of the test file
    task automatic check_retired(input int idx);
        logic [31:0] exp_pc;
        logic [31:0] word;
        logic [4:0] exp_rd;
        logic exp_wen;
        logic [31:0] exp_value;
        logic [1:0] exp_except;
        int errors;
        exp_pc = 32'(idx * 4);
        word = test_field(idx, 2);
        exp_rd = word[4:0];
        word = test_field(idx, 3);
        exp_wen = word[0];
        exp_value = test_field(idx, 4);
        word = test_field(idx, 5);
        exp_except = word[1:0];
        errors = 0;
        if (o_ret_pc != exp_pc) begin
            $display("Mismatch at %0t: o_ret_pc expected %h actual %h",
                     $time, exp_pc, o_ret_pc);
            errors++;
        end
        if (o_ret_rd_idx != exp_rd) begin
            $display("Mismatch at %0t: o_ret_rd_idx expected %h actual %h",
                     $time, exp_rd, o_ret_rd_idx);
            errors++;
        end
        if (o_ret_wen != exp_wen) begin
            $display("Mismatch at %0t: o_ret_wen expected %h actual %h",
                     $time, exp_wen, o_ret_wen);
            errors++;
        end
        if (o_ret_value != exp_value) begin
            $display("Mismatch at %0t: o_ret_value expected %h actual %h",
                     $time, exp_value, o_ret_value);
            errors++;
        end
        if (o_ret_except != exp_except) begin
            $display("Mismatch at %0t: o_ret_except expected %h actual %h",
                     $time, exp_except, o_ret_except);
            errors++;
        end
        if (errors == 0) begin
            pass_count++;
            $display("test %0d (pc %h): ok", idx, exp_pc);
        end else begin
            fail_count++;
            $display("test %0d (pc %h): FAILED with %0d mismatches", idx, exp_pc, errors);
        end
    endtask

    // limit grows with the number of tests read from the file
    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("run timed out after %0d cycles, %0d of %0d tests retired",
                     cycle_count, ret_idx, n_tests);
            $display("Regression failed");
            $finish;
        end
    end

    initial begin
        rst = 1'b1;
        i_inst_vld = 1'b0;
        i_inst = '0;
        i_pc = '0;
        i_fetch_fault = 1'b0;
        i_ret_rdy = 1'b0;
        issue_idx = 0;
        ret_idx = 0;
        pass_count = 0;
        fail_count = 0;
        misc_errors = 0;
        rand_word = $urandom(54);

        // unused rows get a fault column above 1 so the test list ends there
        for (int a = 0; a < MEM_WORDS; a++) begin
            test_mem[MEM_AW'(a)] = 32'hF000_0000 | 32'(a);
        end
        $readmemh("core_tests.txt", test_mem);
        n_tests = 0;
        while (n_tests < MAX_TESTS && test_field(n_tests, 1) <= 32'd1) begin
            n_tests++;
        end
        if (n_tests == 0) begin
            $display("no tests found in core_tests.txt");
            misc_errors++;
        end
        cycle_limit = n_tests * 20 + 100;

        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        if (!o_can_deq || o_ret_vld) begin
            $display("after reset the core is not idle with full credits");
            misc_errors++;
        end

        while (ret_idx < n_tests) begin
            @(posedge clk);
            if (o_ret_vld && i_ret_rdy) begin
                check_retired(ret_idx);
                ret_idx++;
            end
            if (i_inst_vld && o_can_deq) begin
                issue_idx++;
            end
            rand_word = $urandom;
            if (issue_idx < n_tests && rand_word[0]) begin
                row_word = test_field(issue_idx, 1);
                i_inst_vld <= 1'b1;
                i_inst <= test_field(issue_idx, 0);
                i_fetch_fault <= row_word[0];
                i_pc <= 32'(issue_idx * 4);
            end else begin
                i_inst_vld <= 1'b0;
            end
            i_ret_rdy <= rand_word[1];
        end

        // nothing else may come out once every test has retired
        i_inst_vld <= 1'b0;
        i_ret_rdy <= 1'b1;
        repeat (DRAIN_CYCLES) begin
            @(posedge clk);
            if (o_ret_vld) begin
                $display("extra record retired at %0t with pc %h", $time, o_ret_pc);
                misc_errors++;
            end
        end
        if (issue_idx != n_tests) begin
            $display("only %0d of %0d instructions were accepted", issue_idx, n_tests);
            misc_errors++;
        end

        $display("%0d tests passed, %0d failed, %0d other errors",
                 pass_count, fail_count, misc_errors);
        if (fail_count == 0 && misc_errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
    output logic o_clk
);

    localparam int PERIOD_NS = 40;

    initial begin
        o_clk = 1'b0;
    end

    always begin
        #(PERIOD_NS / 2) o_clk = ~o_clk;
    end

endmodule

// File: core_top.sv
`timescale 1ns/1ps

module core_top (
    input  logic clk,
    input  logic rst,

    // fetch buffer
    input  logic i_inst_vld,
    input  logic [31:0] i_inst,
    input  logic [31:0] i_pc,
    input  logic i_fetch_fault,
    output logic o_can_deq,

    // retired records
    input  logic i_ret_rdy,
    output logic o_ret_vld,
    output logic [31:0] o_ret_pc,
    output logic o_ret_wen,
    output logic [4:0] o_ret_rd_idx,
    output logic [31:0] o_ret_value,
    output logic [1:0] o_ret_except
);

    logic dec_vld;
    core_pkg::dec_info_t dec_info;
    logic exe_credit;

    exe_res_if exe_res_i ();

    decode decode_i (
        .clk           (clk),
        .rst           (rst),
        .i_inst_vld    (i_inst_vld),
        .i_inst        (i_inst),
        .i_pc          (i_pc),
        .i_fetch_fault (i_fetch_fault),
        .o_can_deq     (o_can_deq),
        .o_dec_vld     (dec_vld),
        .o_dec_info    (dec_info),
        .i_exe_credit  (exe_credit)
    );

    execute execute_i (
        .clk          (clk),
        .rst          (rst),
        .i_dec_vld    (dec_vld),
        .i_dec_info   (dec_info),
        .o_exe_credit (exe_credit),
        .res          (exe_res_i.execute)
    );

    result result_i (
        .clk          (clk),
        .rst          (rst),
        .res          (exe_res_i.result),
        .i_ret_rdy    (i_ret_rdy),
        .o_ret_vld    (o_ret_vld),
        .o_ret_pc     (o_ret_pc),
        .o_ret_wen    (o_ret_wen),
        .o_ret_rd_idx (o_ret_rd_idx),
        .o_ret_value  (o_ret_value),
        .o_ret_except (o_ret_except)
    );

endmodule

// File: result.sv
`timescale 1ns/1ps

module result (
    input  logic clk,
    input  logic rst,

    // from execute
    exe_res_if.result res,

    // retire side
    input  logic i_ret_rdy,
    output logic o_ret_vld,
    output logic [core_pkg::XLEN-1:0] o_ret_pc,
    output logic o_ret_wen,
    output logic [4:0] o_ret_rd_idx,
    output logic [core_pkg::XLEN-1:0] o_ret_value,
    output core_pkg::except_e o_ret_except
);

    logic [core_pkg::XLEN-1:0] pc_q [core_pkg::RET_QUEUE_DEPTH];
    logic wen_q [core_pkg::RET_QUEUE_DEPTH];
    logic [4:0] rd_q [core_pkg::RET_QUEUE_DEPTH];
    logic [core_pkg::XLEN-1:0] value_q [core_pkg::RET_QUEUE_DEPTH];
    core_pkg::except_e except_q [core_pkg::RET_QUEUE_DEPTH];

    logic [core_pkg::RET_PTR_W-1:0] wr_ptr;
    logic [core_pkg::RET_PTR_W-1:0] rd_ptr;
    logic [core_pkg::RET_CREDIT_W-1:0] count;
    logic pop;

    // head stays put until the consumer takes it
    assign o_ret_vld = (count != '0);
    assign pop = o_ret_vld && i_ret_rdy;
    assign o_ret_pc = pc_q[rd_ptr];
    assign o_ret_wen = wen_q[rd_ptr];
    assign o_ret_rd_idx = rd_q[rd_ptr];
    assign o_ret_value = value_q[rd_ptr];
    assign o_ret_except = except_q[rd_ptr];

    // room is guaranteed by the credits held in execute
    always_ff @(posedge clk) begin
        if (res.vld) begin
            pc_q[wr_ptr] <= res.pc;
            wen_q[wr_ptr] <= res.rd_wen;
            rd_q[wr_ptr] <= res.rd_idx;
            value_q[wr_ptr] <= res.value;
            except_q[wr_ptr] <= res.has_except ? res.except : core_pkg::EXC_NONE;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
            res.credit <= 1'b0;
        end else begin
            res.credit <= pop;
            if (res.vld) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({res.vld, pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// File: execute.sv
`timescale 1ns/1ps

module execute (
    input  logic clk,
    input  logic rst,

    // from decode
    input  logic i_dec_vld,
    input  core_pkg::dec_info_t i_dec_info,
    output logic o_exe_credit,

    // toward result
    exe_res_if.execute res
);

    core_pkg::dec_info_t queue [core_pkg::EXE_QUEUE_DEPTH];
    logic [core_pkg::EXE_PTR_W-1:0] wr_ptr;
    logic [core_pkg::EXE_PTR_W-1:0] rd_ptr;
    logic [core_pkg::EXE_CREDIT_W-1:0] count;
    logic [core_pkg::RET_CREDIT_W-1:0] res_credit;
    logic [core_pkg::XLEN-1:0] regs [32];

    core_pkg::dec_info_t head;
    logic pop;
    logic wr_rd;
    logic [core_pkg::XLEN-1:0] op_a;
    logic [core_pkg::XLEN-1:0] op_b;
    logic [core_pkg::XLEN-1:0] alu_out;
    logic [4:0] shamt;

    assign head = queue[rd_ptr];
    // issue only when the retire queue has room for the result
    assign pop = (count != '0) && (res_credit != '0);
    assign wr_rd = pop && head.rd_wen && (head.rd_idx != 5'd0);

    always_ff @(posedge clk) begin
        if (i_dec_vld) begin
            queue[wr_ptr] <= i_dec_info;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
            res_credit <= core_pkg::RET_CREDIT_INIT;
            o_exe_credit <= 1'b0;
        end else begin
            o_exe_credit <= pop;
            if (i_dec_vld) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({i_dec_vld, pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
            case ({pop, res.credit})
                2'b10: res_credit <= res_credit - 1'b1;
                2'b01: res_credit <= res_credit + 1'b1;
                default: res_credit <= res_credit;
            endcase
        end
    end

    // x0 reads as zero
    assign op_a = (head.rs1_idx == 5'd0) ? '0 : regs[head.rs1_idx];
    assign op_b = head.use_imm ? head.imm :
                  ((head.rs2_idx == 5'd0) ? '0 : regs[head.rs2_idx]);
    assign shamt = op_b[4:0];

    always_comb begin
        case (head.micro_op)
            core_pkg::UOP_ADD: alu_out = op_a + op_b;
            core_pkg::UOP_SUB: alu_out = op_a - op_b;
            core_pkg::UOP_AND: alu_out = op_a & op_b;
            core_pkg::UOP_OR: alu_out = op_a | op_b;
            core_pkg::UOP_XOR: alu_out = op_a ^ op_b;
            core_pkg::UOP_SLT: alu_out = {{(core_pkg::XLEN - 1){1'b0}},
                                          ($signed(op_a) < $signed(op_b))};
            core_pkg::UOP_SLL: alu_out = op_a << shamt;
            core_pkg::UOP_SRL: alu_out = op_a >> shamt;
            core_pkg::UOP_SRA: alu_out = $signed(op_a) >>> shamt;
            core_pkg::UOP_LUI: alu_out = op_b;
            default: alu_out = '0;
        endcase
    end

    // write on the pop edge so the next head sees the new value
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int k = 0; k < 32; k++) begin
                regs[k] <= '0;
            end
        end else if (wr_rd) begin
            regs[head.rd_idx] <= alu_out;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            res.vld <= 1'b0;
        end else begin
            res.vld <= pop;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            res.pc <= head.pc;
            res.rd_wen <= wr_rd;
            res.rd_idx <= head.rd_idx;
            res.value <= head.has_except ? '0 : alu_out;
            res.has_except <= head.has_except;
            res.except <= head.except;
        end
    end

endmodule

// File: decode.sv
`timescale 1ns/1ps

module decode (
    input  logic clk,
    input  logic rst,

    // fetch buffer side
    input  logic i_inst_vld,
    input  core_pkg::inst_word_u i_inst,
    input  logic [core_pkg::XLEN-1:0] i_pc,
    input  logic i_fetch_fault,
    output logic o_can_deq,

    // toward execute
    output logic o_dec_vld,
    output core_pkg::dec_info_t o_dec_info,
    input  logic i_exe_credit
);

    logic unknown;
    logic take;
    core_pkg::dec_info_t dec_raw;
    core_pkg::dec_info_t dec_merged;
    logic [core_pkg::EXE_CREDIT_W-1:0] credit;

    inst_decoder inst_decoder_i (
        .i_inst     (i_inst),
        .i_pc       (i_pc),
        .o_unknown  (unknown),
        .o_dec_info (dec_raw)
    );

    // a free slot in the execute queue is all that is needed to accept
    assign o_can_deq = (credit != '0);
    assign take = i_inst_vld && o_can_deq;

    // fetch fault wins over an illegal encoding
    always_comb begin
        dec_merged = dec_raw;
        dec_merged.has_except = i_fetch_fault || unknown;
        if (i_fetch_fault) begin
            dec_merged.except = core_pkg::EXC_INST_FAULT;
        end else if (unknown) begin
            dec_merged.except = core_pkg::EXC_INST_ILLEGAL;
        end else begin
            dec_merged.except = core_pkg::EXC_NONE;
        end
        if (dec_merged.has_except) begin
            dec_merged.rd_wen = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            credit <= core_pkg::EXE_CREDIT_INIT;
            o_dec_vld <= 1'b0;
        end else begin
            o_dec_vld <= take;
            case ({take, i_exe_credit})
                2'b10: credit <= credit - 1'b1;
                2'b01: credit <= credit + 1'b1;
                default: credit <= credit;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            o_dec_info <= dec_merged;
        end
    end

endmodule

// File: inst_decoder.sv
`timescale 1ns/1ps

module inst_decoder (
    input  core_pkg::inst_word_u i_inst,
    input  logic [core_pkg::XLEN-1:0] i_pc,
    output logic o_unknown,
    output core_pkg::dec_info_t o_dec_info
);

    logic known;
    logic use_imm;
    logic [core_pkg::XLEN-1:0] imm;
    core_pkg::micro_op_e op;

    always_comb begin
        known = 1'b1;
        use_imm = 1'b0;
        imm = '0;
        op = core_pkg::UOP_ADD;
        case (i_inst.r.opcode)
            core_pkg::OPC_OP: begin
                if (i_inst.r.funct7 == core_pkg::F7_BASE) begin
                    case (i_inst.r.funct3)
                        core_pkg::F3_ADD_SUB: op = core_pkg::UOP_ADD;
                        core_pkg::F3_SLL: op = core_pkg::UOP_SLL;
                        core_pkg::F3_SLT: op = core_pkg::UOP_SLT;
                        core_pkg::F3_XOR: op = core_pkg::UOP_XOR;
                        core_pkg::F3_SRL_SRA: op = core_pkg::UOP_SRL;
                        core_pkg::F3_OR: op = core_pkg::UOP_OR;
                        core_pkg::F3_AND: op = core_pkg::UOP_AND;
                        // sltu has no micro-op here
                        default: known = 1'b0;
                    endcase
                end else if (i_inst.r.funct7 == core_pkg::F7_ALT) begin
                    case (i_inst.r.funct3)
                        core_pkg::F3_ADD_SUB: op = core_pkg::UOP_SUB;
                        core_pkg::F3_SRL_SRA: op = core_pkg::UOP_SRA;
                        default: known = 1'b0;
                    endcase
                end else begin
                    known = 1'b0;
                end
            end
            core_pkg::OPC_OP_IMM: begin
                use_imm = 1'b1;
                imm = {{(core_pkg::XLEN - 12){i_inst.i.imm[11]}}, i_inst.i.imm};
                case (i_inst.i.funct3)
                    core_pkg::F3_ADD_SUB: op = core_pkg::UOP_ADD;
                    core_pkg::F3_SLT: op = core_pkg::UOP_SLT;
                    core_pkg::F3_XOR: op = core_pkg::UOP_XOR;
                    core_pkg::F3_OR: op = core_pkg::UOP_OR;
                    core_pkg::F3_AND: op = core_pkg::UOP_AND;
                    // shifts keep funct7 in the upper immediate bits
                    core_pkg::F3_SLL: begin
                        op = core_pkg::UOP_SLL;
                        known = (i_inst.i.imm[11:5] == core_pkg::F7_BASE);
                    end
                    core_pkg::F3_SRL_SRA: begin
                        if (i_inst.i.imm[11:5] == core_pkg::F7_BASE) begin
                            op = core_pkg::UOP_SRL;
                        end else if (i_inst.i.imm[11:5] == core_pkg::F7_ALT) begin
                            op = core_pkg::UOP_SRA;
                        end else begin
                            known = 1'b0;
                        end
                    end
                    default: known = 1'b0;
                endcase
            end
            core_pkg::OPC_LUI: begin
                op = core_pkg::UOP_LUI;
                use_imm = 1'b1;
                imm = {i_inst.u.imm, 12'b0};
            end
            default: known = 1'b0;
        endcase
    end

    assign o_unknown = !known;

    // rs fields are zeroed where the format has no such operand
    assign o_dec_info = '{
        pc: i_pc,
        micro_op: op,
        rd_wen: known,
        rd_idx: i_inst.r.rd,
        rs1_idx: (i_inst.r.opcode == core_pkg::OPC_LUI) ? 5'd0 : i_inst.r.rs1,
        rs2_idx: use_imm ? 5'd0 : i_inst.r.rs2,
        use_imm: use_imm,
        imm: imm,
        has_except: !known,
        except: known ? core_pkg::EXC_NONE : core_pkg::EXC_INST_ILLEGAL
    };

endmodule

// File: exe_res_if.sv
`timescale 1ns/1ps

interface exe_res_if;

    // executed record valid for one cycle per retired instruction
    logic vld;
    logic [core_pkg::XLEN-1:0] pc;
    logic rd_wen;
    logic [4:0] rd_idx;
    logic [core_pkg::XLEN-1:0] value;
    logic has_except;
    core_pkg::except_e except;

    // one pulse per entry freed in the retire queue
    logic credit;

    modport execute (
        output vld, pc, rd_wen, rd_idx, value, has_except, except,
        input  credit
    );

    modport result (
        input  vld, pc, rd_wen, rd_idx, value, has_except, except,
        output credit
    );

endinterface

// File: core_pkg.sv
package core_pkg;

    // queue depths double as the initial credit count of each producer
    // depths are powers of two so the queue pointers wrap on their own
    localparam int EXE_QUEUE_DEPTH = 4;
    localparam int RET_QUEUE_DEPTH = 4;
    localparam int XLEN = 32;

    localparam int EXE_PTR_W = $clog2(EXE_QUEUE_DEPTH);
    localparam int RET_PTR_W = $clog2(RET_QUEUE_DEPTH);
    localparam int EXE_CREDIT_W = $clog2(EXE_QUEUE_DEPTH + 1);
    localparam int RET_CREDIT_W = $clog2(RET_QUEUE_DEPTH + 1);
    localparam logic [EXE_CREDIT_W-1:0] EXE_CREDIT_INIT = EXE_CREDIT_W'(EXE_QUEUE_DEPTH);
    localparam logic [RET_CREDIT_W-1:0] RET_CREDIT_INIT = RET_CREDIT_W'(RET_QUEUE_DEPTH);

    // supported major opcodes
    localparam logic [6:0] OPC_OP = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI = 7'b0110111;

    // funct7 for base and alternate forms (sub, sra)
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT = 7'b0100000;

    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL = 3'b001;
    localparam logic [2:0] F3_SLT = 3'b010;
    localparam logic [2:0] F3_XOR = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;

    // one instruction word read through the view its opcode selects
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } i;
        struct packed {
            logic [19:0] imm;
            logic [4:0] rd;
            logic [6:0] opcode;
        } u;
    } inst_word_u;

    typedef enum logic [3:0] {
        UOP_ADD,
        UOP_SUB,
        UOP_AND,
        UOP_OR,
        UOP_XOR,
        UOP_SLT,
        UOP_SLL,
        UOP_SRL,
        UOP_SRA,
        UOP_LUI
    } micro_op_e;

    typedef enum logic [1:0] {
        EXC_NONE,
        EXC_INST_FAULT,
        EXC_INST_ILLEGAL
    } except_e;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        micro_op_e micro_op;
        logic rd_wen;
        logic [4:0] rd_idx;
        logic [4:0] rs1_idx;
        logic [4:0] rs2_idx;
        logic use_imm;
        // sign-extended I immediate, or U immediate already shifted
        logic [XLEN-1:0] imm;
        logic has_except;
        except_e except;
    } dec_info_t;

endpackage
